//--- logic/connect_pkg.sv
package connect_pkg;

    ////////////////////////////////////////////////////////////
    // board geometry
    ////////////////////////////////////////////////////////////

    localparam int ROWS    = 7;
    localparam int COLS    = 7;
    localparam int BOARD_W = 2 * ROWS * COLS;

    // player select for plane extraction
    localparam logic PLAYER_AI  = 1'b0;
    localparam logic PLAYER_OPP = 1'b1;

    // two bits per cell, computer stone in the low bit
    typedef struct packed {
        logic opp;
        logic ai;
    } cell_t;

    // row 0 is the bottom row, column 0 the left edge
    typedef union packed {
        logic [BOARD_W-1:0]                flat;
        cell_t [ROWS-1:0][COLS-1:0]        cells;
    } board_u;

    typedef logic [ROWS-1:0][COLS-1:0] plane_t;

    typedef struct packed {
        logic [2:0] row;
        logic [2:0] col;
    } pos_t;

    typedef struct packed {
        board_u board;
        pos_t   ai_pos;
        pos_t   opp_pos;
    } eval_req_t;

    ////////////////////////////////////////////////////////////
    // results and scoring
    ////////////////////////////////////////////////////////////

    // up to 10 threes through one stone
    localparam int THREE_W = 4;
    localparam int SCORE_W = 9;

    typedef struct packed {
        logic               valid;
        logic [2:0]         col;
        logic               four;
        logic [THREE_W-1:0] threes;
    } line_stats_t;

    typedef logic [SCORE_W-1:0] score_t;

    localparam score_t WIN_SCORE    = 9'd511;
    localparam score_t LOSS_SCORE   = 9'd0;
    localparam score_t BASE_SCORE   = 9'd200;
    localparam score_t THREE_WEIGHT = 9'd10;

    // pull one player's stones out of the cell grid
    function automatic plane_t player_plane(
        input board_u board,
        input logic   sel
    );
        plane_t plane;
        for (int r = 0; r < ROWS; r++)
        begin
            for (int c = 0; c < COLS; c++)
            begin
                if (sel == PLAYER_OPP)
                    plane[r][c] = board.cells[r][c].opp;
                else
                    plane[r][c] = board.cells[r][c].ai;
            end
        end
        return plane;
    endfunction

endpackage

//--- logic/line_scan.sv
`timescale 1ns/1ps

module line_scan
    import connect_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    input  plane_t      plane,
    input  pos_t        pos,
    output line_stats_t stats
);

    ////////////////////////////////////////////////////////////
    // window test
    ////////////////////////////////////////////////////////////

    // len cells starting at pos + start*dir, every one on the board and set
    function automatic logic window_hit(
        input plane_t pl,
        input int     row,
        input int     col,
        input int     dr,
        input int     dc,
        input int     start,
        input int     len
    );
        int   r;
        int   c;
        logic hit;
        hit = 1'b1;
        for (int i = 0; i < 4; i++)
        begin
            if (i < len)
            begin
                r = row + (start + i) * dr;
                c = col + (start + i) * dc;
                // off-board cells kill the window, no row wrap
                if (r < 0 || r >= ROWS || c < 0 || c >= COLS)
                    hit = 1'b0;
                else if (!pl[r][c])
                    hit = 1'b0;
            end
        end
        return hit;
    endfunction

    int                 stone_row;
    int                 stone_col;

    // one bit per window, index k = stone offset from window start
    logic [3:0]         horiz4;
    logic [3:0]         rise4;
    logic [3:0]         fall4;
    logic               vert4;
    logic [2:0]         horiz3;
    logic [2:0]         rise3;
    logic [2:0]         fall3;
    logic               vert3;

    logic [9:0]         three_hits;
    logic               four_c;
    logic [THREE_W-1:0] threes_c;

    logic               valid_q;
    logic [2:0]         col_q;
    logic               four_q;
    logic [THREE_W-1:0] threes_q;

    assign stone_row = int'(pos.row);
    assign stone_col = int'(pos.col);

    ////////////////////////////////////////////////////////////
    // fours
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        for (int k = 0; k < 4; k++)
        begin
            horiz4[k] = window_hit(plane, stone_row, stone_col, 0, 1, -k, 4);
            rise4[k]  = window_hit(plane, stone_row, stone_col, 1, 1, -k, 4);
            fall4[k]  = window_hit(plane, stone_row, stone_col, -1, 1, -k, 4);
        end
        // newest stone is on top of its column, so only look down
        vert4 = window_hit(plane, stone_row, stone_col, -1, 0, 0, 4);
    end

    assign four_c = (|horiz4) | (|rise4) | (|fall4) | vert4;

    ////////////////////////////////////////////////////////////
    // threes
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        for (int k = 0; k < 3; k++)
        begin
            horiz3[k] = window_hit(plane, stone_row, stone_col, 0, 1, -k, 3);
            rise3[k]  = window_hit(plane, stone_row, stone_col, 1, 1, -k, 3);
            fall3[k]  = window_hit(plane, stone_row, stone_col, -1, 1, -k, 3);
        end
        vert3 = window_hit(plane, stone_row, stone_col, -1, 0, 0, 3);
    end

    assign three_hits = {vert3, fall3, rise3, horiz3};

    always_comb
    begin
        threes_c = '0;
        for (int i = 0; i < $bits(three_hits); i++)
            threes_c = threes_c + THREE_W'(three_hits[i]);
    end

    ////////////////////////////////////////////////////////////
    // stage 1 register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            col_q    <= pos.col;
            four_q   <= four_c;
            threes_q <= threes_c;
        end
    end

    assign stats = '{valid: valid_q, col: col_q, four: four_q, threes: threes_q};

endmodule

//--- logic/move_scorer.sv
`timescale 1ns/1ps

module move_scorer
    import connect_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  line_stats_t ai_stats,
    input  line_stats_t opp_stats,
    output logic        out_valid,
    output score_t      score
);

    logic [2:0] edge_dist;
    score_t     centre_w;
    score_t     ai_bonus;
    score_t     opp_bonus;
    score_t     score_c;

    // distance of the computer's column to the nearer side
    always_comb
    begin
        if (ai_stats.col > 3'(COLS / 2))
            edge_dist = 3'(COLS - 1) - ai_stats.col;
        else
            edge_dist = ai_stats.col;
    end

    // 2*dist + 1 gives 1,3,5,7,5,3,1
    assign centre_w  = score_t'({edge_dist, 1'b1});
    assign ai_bonus  = THREE_WEIGHT * score_t'(ai_stats.threes);
    assign opp_bonus = THREE_WEIGHT * score_t'(opp_stats.threes);

    // mixed sum stays in 101..307, never wraps
    always_comb
    begin
        if (ai_stats.four)
            score_c = WIN_SCORE;
        else if (opp_stats.four)
            score_c = LOSS_SCORE;
        else
            score_c = BASE_SCORE + ai_bonus + centre_w - opp_bonus;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            out_valid <= 1'b0;
            score     <= '0;
        end
        else
        begin
            out_valid <= ai_stats.valid;
            if (ai_stats.valid)
                score <= score_c;
        end
    end

endmodule

//--- logic/connect_eval_top.sv
`timescale 1ns/1ps

module connect_eval_top
    import connect_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      in_valid,
    input  eval_req_t req,
    output logic      out_valid,
    output score_t    score
);

    plane_t      ai_plane;
    plane_t      opp_plane;
    line_stats_t ai_stats;
    line_stats_t opp_stats;

    // split the shared board into one plane per player
    assign ai_plane  = player_plane(req.board, PLAYER_AI);
    assign opp_plane = player_plane(req.board, PLAYER_OPP);

    line_scan u_ai_scan (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .plane    (ai_plane),
        .pos      (req.ai_pos),
        .stats    (ai_stats)
    );

    line_scan u_opp_scan (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .plane    (opp_plane),
        .pos      (req.opp_pos),
        .stats    (opp_stats)
    );

    // valid and column come from the computer side only
    move_scorer u_scorer (
        .clk       (clk),
        .arst_n    (arst_n),
        .ai_stats  (ai_stats),
        .opp_stats (opp_stats),
        .out_valid (out_valid),
        .score     (score)
    );

endmodule

//--- dv/connect_eval_tb.sv
`timescale 1ns/1ps

module connect_eval_tb
    import connect_pkg::*;
();

    localparam int DRAIN_LIMIT = 20;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    eval_req_t   req;
    logic        out_valid;
    score_t      score;

    int unsigned cycle = 0;
    int unsigned rand_state;
    int          errors;
    int          timeouts;

    // trace contents
    logic [BOARD_W-1:0] trace_board[$];
    pos_t               trace_ai[$];
    pos_t               trace_opp[$];
    score_t             trace_score[$];

    // pending results in request order
    score_t      exp_q[$];
    int unsigned cyc_q[$];

    score_t      exp_s;
    int unsigned exp_c;

    connect_eval_top u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .req       (req),
        .out_valid (out_valid),
        .score     (score)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    // 32-bit linear congruential step
    function automatic int unsigned next_rand(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    ////////////////////////////////////////////////////////////
    // trace file
    ////////////////////////////////////////////////////////////

    task automatic load_trace();
        int                 fd;
        int                 n;
        int                 ar;
        int                 ac;
        int                 orow;
        int                 oc;
        int                 sc;
        string              line;
        logic [BOARD_W-1:0] b;
        pos_t               ap;
        pos_t               op;
        fd = $fopen("dv/eval_trace.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the trace file dv/eval_trace.txt");
            errors++;
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line.getc(0) != 8'h23)
            begin
                n = $sscanf(line, "%h %d %d %d %d %d", b, ar, ac, orow, oc, sc);
                if (n == 6)
                begin
                    ap.row = 3'(ar);
                    ap.col = 3'(ac);
                    op.row = 3'(orow);
                    op.col = 3'(oc);
                    trace_board.push_back(b);
                    trace_ai.push_back(ap);
                    trace_opp.push_back(op);
                    trace_score.push_back(score_t'(sc));
                end
            end
        end
        $fclose(fd);
        if (trace_board.size() == 0)
        begin
            $display("trace file holds no requests");
            errors++;
        end
    endtask

    // one request on the current falling edge
    task automatic drive_request(input int idx);
        in_valid          = 1'b1;
        req.board.flat    = trace_board[idx];
        req.ai_pos        = trace_ai[idx];
        req.opp_pos       = trace_opp[idx];
        exp_q.push_back(trace_score[idx]);
        // sampled on the falling edge after the second register
        cyc_q.push_back(cycle + 2);
    endtask

    ////////////////////////////////////////////////////////////
    // result checker
    ////////////////////////////////////////////////////////////

    always @(negedge clk)
    begin
        if (arst_n)
        begin
            if (out_valid)
            begin
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("out_valid high at %0t with no request pending", $time);
                end
                else
                begin
                    exp_s = exp_q.pop_front();
                    exp_c = cyc_q.pop_front();
                    if (exp_c != cycle)
                    begin
                        errors++;
                        $display("** Error %0t: out_valid cycle expected %0d actual %0d",
                                 $time, exp_c, cycle);
                    end
                    if (score != exp_s)
                    begin
                        errors++;
                        $display("** Error %0t: score expected %0d actual %0d",
                                 $time, exp_s, score);
                    end
                end
            end
            else if (cyc_q.size() > 0 && cyc_q[0] <= cycle)
            begin
                errors++;
                $display("result missing at %0t, out_valid stayed low", $time);
                exp_s = exp_q.pop_front();
                exp_c = cyc_q.pop_front();
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial
    begin
        int wait_cnt;
        int gap;
        clk        = 1'b0;
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        req        = '0;
        rand_state = 40753;
        errors     = 0;
        timeouts   = 0;

        load_trace();

        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        // idle a few cycles with out_valid low
        repeat (4) @(negedge clk);

        for (int i = 0; i < trace_board.size(); i++)
        begin
            rand_state = next_rand(rand_state);
            gap = int'((rand_state >> 16) % 4);
            if (gap > 0)
            begin
                in_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
            drive_request(i);
            @(negedge clk);
        end
        in_valid = 1'b0;

        wait_cnt = 0;
        while (exp_q.size() > 0 && wait_cnt < DRAIN_LIMIT)
        begin
            @(negedge clk);
            wait_cnt++;
        end
        if (exp_q.size() > 0)
        begin
            timeouts++;
            $display("timed out waiting for %0d outstanding results", exp_q.size());
        end
        // catch stray pulses after the last result
        repeat (4) @(negedge clk);

        $display("requests: %0d, errors: %0d, timeouts: %0d",
                 trace_board.size(), errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- dv/eval_trace.txt
# columns: board hex (cell r,c at bits 14r+2c ai, 14r+2c+1 opp), ai row, ai col,
# opp row, opp col, expected score (decimal)
# empty board, pure centre weight per column
8001 0 0 1 0 201
20004 0 1 1 1 203
80010 0 2 1 2 205
200040 0 3 1 3 207
800100 0 4 1 4 205
2000400 0 5 1 5 203
8001000 0 6 1 6 201
# computer fours
55 0 0 1 0 511
80154 0 2 1 2 511
40010004009 3 0 0 1 511
1000100010009 1 1 0 1 511
40040040042 0 3 0 0 511
15500000000002 3 3 0 0 511
# both have fours, computer wins
2a8055 0 0 1 0 511
# opponent fours
40aa 1 0 0 3 0
80020008002001 0 0 3 6 0
2002002002001 0 0 2 4 0
# mixed threes
200150 0 3 1 3 217
a9000 0 6 1 2 191
11005401500100080 3 3 0 3 247
150010a84 2 1 0 5 213
4200102402 2 5 2 2 203
2000a80021 0 0 1 3 181
# edges, no wrap across rows
5502 1 0 0 0 201
1500000000000000020008002 6 6 2 0 201
# stones above but not below
400100040090 0 2 0 3 205
# second pass for back-to-back coverage
8001 0 0 1 0 201
55 0 0 1 0 511
40aa 1 0 0 3 0
200040 0 3 1 3 207
11005401500100080 3 3 0 3 247
2000a80021 0 0 1 3 181
5502 1 0 0 0 201
8001000 0 6 1 6 201
2a8055 0 0 1 0 511
150010a84 2 1 0 5 213

//--- sources.f
logic/connect_pkg.sv
logic/line_scan.sv
logic/move_scorer.sv
logic/connect_eval_top.sv
dv/connect_eval_tb.sv

//--- Makefile
# Verilator build and run for the move evaluator

VERILATOR ?= verilator
TOP       ?= connect_eval_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
